// File: Makefile
VERILATOR ?= verilator
TOP       ?= platformer_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
hw/platformer_pkg.sv
hw/key_decoder.sv
hw/terrain_collision.sv
hw/player_motion.sv
hw/snowflake_tracker.sv
hw/platformer_core.sv
sim/tb_clock.sv
sim/platformer_tb.sv

// File: hw/key_decoder.sv
`timescale 1ns/1ps

module key_decoder (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       scan_valid_i,
    input  logic [7:0] scan_code_i,
    input  logic       scan_break_i,
    input  logic       respawn_done_i,
    output logic       scan_ready_o,
    output logic       hold_jump_o,
    output logic       hold_left_o,
    output logic       hold_right_o,
    output logic       respawn_req_o
);

    platformer_pkg::key_e cmd;
    logic                 accept;

    // codes wait at the input while a respawn is pending
    assign scan_ready_o = !respawn_req_o;
    assign accept       = scan_valid_i && scan_ready_o;

    always_comb begin
        case (scan_code_i)
            platformer_pkg::KEY_W: cmd = platformer_pkg::CMD_JUMP;
            platformer_pkg::KEY_A: cmd = platformer_pkg::CMD_LEFT;
            platformer_pkg::KEY_D: cmd = platformer_pkg::CMD_RIGHT;
            platformer_pkg::KEY_R: cmd = platformer_pkg::CMD_RESPAWN;
            default:               cmd = platformer_pkg::CMD_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hold_jump_o   <= 1'b0;
            hold_left_o   <= 1'b0;
            hold_right_o  <= 1'b0;
            respawn_req_o <= 1'b0;
        end else if (accept) begin
            // make sets the held bit, break clears it
            case (cmd)
                platformer_pkg::CMD_JUMP:    hold_jump_o  <= !scan_break_i;
                platformer_pkg::CMD_LEFT:    hold_left_o  <= !scan_break_i;
                platformer_pkg::CMD_RIGHT:   hold_right_o <= !scan_break_i;
                platformer_pkg::CMD_RESPAWN: respawn_req_o <= !scan_break_i;
                default: ;
            endcase
        end else if (respawn_done_i) begin
            respawn_req_o <= 1'b0;
        end
    end

    // motion only serves a respawn that was asked for
    assert property (@(posedge clk) disable iff (rst_i)
        respawn_done_i |-> respawn_req_o);

endmodule

// File: hw/platformer_core.sv
`timescale 1ns/1ps

module platformer_core #(
    parameter int TICK_DIV    = 100_000,
    parameter int WALK_PERIOD = 125
) (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               scan_valid_i,
    input  logic [7:0]                         scan_code_i,
    input  logic                               scan_break_i,
    output logic                               scan_ready_o,
    output logic [platformer_pkg::X_W-1:0]     pos_x_o,
    output logic [platformer_pkg::Y_W-1:0]     pos_y_o,
    output logic                               facing_right_o,
    output platformer_pkg::air_e               air_state_o,
    output logic [platformer_pkg::SCORE_W-1:0] score_o,
    output logic                               won_o
);

    logic hold_jump;
    logic hold_left;
    logic hold_right;
    logic respawn_req;
    logic respawn_done;
    logic hit_down;
    logic hit_up;
    logic hit_right;
    logic hit_left;

    key_decoder u_keys (
        .clk            (clk),
        .rst_i          (rst_i),
        .scan_valid_i   (scan_valid_i),
        .scan_code_i    (scan_code_i),
        .scan_break_i   (scan_break_i),
        .respawn_done_i (respawn_done),
        .scan_ready_o   (scan_ready_o),
        .hold_jump_o    (hold_jump),
        .hold_left_o    (hold_left),
        .hold_right_o   (hold_right),
        .respawn_req_o  (respawn_req)
    );

    terrain_collision u_terrain (
        .clk         (clk),
        .rst_i       (rst_i),
        .pos_x_i     (pos_x_o),
        .pos_y_i     (pos_y_o),
        .hit_down_o  (hit_down),
        .hit_up_o    (hit_up),
        .hit_right_o (hit_right),
        .hit_left_o  (hit_left)
    );

    player_motion #(
        .TICK_DIV    (TICK_DIV),
        .WALK_PERIOD (WALK_PERIOD)
    ) u_motion (
        .clk            (clk),
        .rst_i          (rst_i),
        .hold_jump_i    (hold_jump),
        .hold_left_i    (hold_left),
        .hold_right_i   (hold_right),
        .respawn_req_i  (respawn_req),
        .hit_down_i     (hit_down),
        .hit_up_i       (hit_up),
        .hit_right_i    (hit_right),
        .hit_left_i     (hit_left),
        .pos_x_o        (pos_x_o),
        .pos_y_o        (pos_y_o),
        .facing_right_o (facing_right_o),
        .air_state_o    (air_state_o),
        .respawn_done_o (respawn_done)
    );

    snowflake_tracker u_flakes (
        .clk     (clk),
        .rst_i   (rst_i),
        .pos_x_i (pos_x_o),
        .pos_y_i (pos_y_o),
        .score_o (score_o),
        .won_o   (won_o)
    );

endmodule

// File: hw/platformer_pkg.sv
package platformer_pkg;

    // screen coordinate widths
    localparam int X_W     = 10;
    localparam int Y_W     = 9;
    localparam int SCORE_W = 4;

    // sprite boxes in pixels
    localparam int PLAYER_W = 47;
    localparam int PLAYER_H = 33;
    localparam int BLOCK_W  = 25;
    localparam int BLOCK_H  = 42;
    localparam int FLAKE_W  = 24;
    localparam int FLAKE_H  = 26;

    // player bottom rests on the floor top at 400
    localparam logic [X_W-1:0] SPAWN_X = X_W'(0);
    localparam logic [Y_W-1:0] SPAWN_Y = Y_W'(367);

    // floor, then left platform, then right platform
    localparam int BLOCK_NUM = 36;
    localparam logic [X_W-1:0] BLOCK_X [BLOCK_NUM] = '{
        0, 25, 50, 75, 100, 125, 150, 175, 200, 225, 250,
        275, 300, 325, 350, 375, 400, 425, 450, 475, 500, 525,
        100, 125, 150, 175, 200, 225, 250,
        300, 325, 350, 375, 400, 425, 450
    };
    localparam logic [Y_W-1:0] BLOCK_Y [BLOCK_NUM] = '{
        400, 400, 400, 400, 400, 400, 400, 400, 400, 400, 400,
        400, 400, 400, 400, 400, 400, 400, 400, 400, 400, 400,
        310, 310, 310, 310, 310, 310, 310,
        310, 310, 310, 310, 310, 310, 310
    };

    // four on the floor, two above the platforms
    localparam int FLAKE_NUM = 6;
    localparam logic [X_W-1:0] FLAKE_X [FLAKE_NUM] = '{144, 184, 224, 264, 150, 350};
    localparam logic [Y_W-1:0] FLAKE_Y [FLAKE_NUM] = '{370, 370, 370, 370, 250, 250};

    // vertical speed profile, in ticks per pixel
    localparam int PERIOD_W = 8;
    localparam int STEP_W   = 5;
    localparam logic [PERIOD_W-1:0] JUMP_START_PERIOD = PERIOD_W'(25);
    localparam logic [PERIOD_W-1:0] JUMP_END_PERIOD   = PERIOD_W'(50);
    localparam logic [PERIOD_W-1:0] FALL_START_PERIOD = PERIOD_W'(50);
    localparam logic [PERIOD_W-1:0] FALL_MIN_PERIOD   = PERIOD_W'(20);
    localparam logic [PERIOD_W-1:0] PERIOD_STEP       = PERIOD_W'(5);
    localparam logic [STEP_W-1:0]   PIXELS_PER_STEP   = STEP_W'(24);

    // keyboard set 2 make codes
    localparam logic [7:0] KEY_W = 8'h1D;
    localparam logic [7:0] KEY_A = 8'h1C;
    localparam logic [7:0] KEY_D = 8'h23;
    localparam logic [7:0] KEY_R = 8'h2D;

    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_JUMP,
        CMD_LEFT,
        CMD_RIGHT,
        CMD_RESPAWN
    } key_e;

    typedef enum logic [1:0] {
        AIR_GROUNDED,
        AIR_RISING,
        AIR_FALLING
    } air_e;

endpackage

// File: hw/player_motion.sv
`timescale 1ns/1ps

module player_motion #(
    parameter int TICK_DIV    = 100_000,
    parameter int WALK_PERIOD = 125
) (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           hold_jump_i,
    input  logic                           hold_left_i,
    input  logic                           hold_right_i,
    input  logic                           respawn_req_i,
    input  logic                           hit_down_i,
    input  logic                           hit_up_i,
    input  logic                           hit_right_i,
    input  logic                           hit_left_i,
    output logic [platformer_pkg::X_W-1:0] pos_x_o,
    output logic [platformer_pkg::Y_W-1:0] pos_y_o,
    output logic                           facing_right_o,
    output platformer_pkg::air_e           air_state_o,
    output logic                           respawn_done_o
);

    localparam int TICK_W = $clog2(TICK_DIV + 1);
    localparam int WALK_W = $clog2(WALK_PERIOD + 1);
    localparam int PER_W  = platformer_pkg::PERIOD_W;

    logic [TICK_W-1:0]                 tick_cnt;
    logic                              tick;
    logic [WALK_W-1:0]                 walk_cnt;
    logic                              walk_left;
    logic                              walk_right;
    logic [PER_W-1:0]                  period;
    logic [PER_W-1:0]                  air_cnt;
    logic [platformer_pkg::STEP_W-1:0] step_pix;
    logic                              px_due;
    logic                              step_due;

    // one game tick every TICK_DIV clocks
    always_ff @(posedge clk) begin
        if (rst_i || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign tick           = (tick_cnt == TICK_W'(TICK_DIV - 1));
    assign respawn_done_o = tick && respawn_req_i;

    // right wins when both are held
    assign walk_left  = hold_left_i && !hold_right_i && !hit_left_i;
    assign walk_right = hold_right_i && !hit_right_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pos_x_o        <= platformer_pkg::SPAWN_X;
            facing_right_o <= 1'b1;
            walk_cnt       <= '0;
        end else if (respawn_done_o) begin
            pos_x_o  <= platformer_pkg::SPAWN_X;
            walk_cnt <= '0;
        end else if (tick) begin
            if (walk_left || walk_right) begin
                facing_right_o <= walk_right;
                if (walk_cnt == WALK_W'(WALK_PERIOD - 1)) begin
                    walk_cnt <= '0;
                    pos_x_o  <= walk_right ? pos_x_o + 1'b1 : pos_x_o - 1'b1;
                end else begin
                    walk_cnt <= walk_cnt + 1'b1;
                end
            end else begin
                walk_cnt <= '0;
            end
        end
    end

    // pixel due this tick, and the speed changes after every 24th pixel
    assign px_due   = (air_cnt == period - 1'b1);
    assign step_due = px_due && (step_pix == platformer_pkg::PIXELS_PER_STEP - 1'b1);

    always_ff @(posedge clk) begin
        if (rst_i || respawn_done_o) begin
            pos_y_o     <= platformer_pkg::SPAWN_Y;
            air_state_o <= platformer_pkg::AIR_GROUNDED;
            period      <= platformer_pkg::FALL_START_PERIOD;
            air_cnt     <= '0;
            step_pix    <= '0;
        end else if (tick) begin
            case (air_state_o)
                platformer_pkg::AIR_GROUNDED: begin
                    air_cnt  <= '0;
                    step_pix <= '0;
                    if (hold_jump_i && hit_down_i) begin
                        air_state_o <= platformer_pkg::AIR_RISING;
                        period      <= platformer_pkg::JUMP_START_PERIOD;
                    end else if (!hit_down_i) begin
                        // walked off an edge
                        air_state_o <= platformer_pkg::AIR_FALLING;
                        period      <= platformer_pkg::FALL_START_PERIOD;
                    end
                end
                platformer_pkg::AIR_RISING: begin
                    if (hit_up_i || period >= platformer_pkg::JUMP_END_PERIOD) begin
                        air_state_o <= platformer_pkg::AIR_FALLING;
                        period      <= platformer_pkg::FALL_START_PERIOD;
                        air_cnt     <= '0;
                        step_pix    <= '0;
                    end else if (px_due) begin
                        air_cnt  <= '0;
                        pos_y_o  <= pos_y_o - 1'b1;
                        step_pix <= step_due ? '0 : step_pix + 1'b1;
                        if (step_due) begin
                            period <= period + platformer_pkg::PERIOD_STEP;
                        end
                    end else begin
                        air_cnt <= air_cnt + 1'b1;
                    end
                end
                default: begin
                    if (hit_down_i) begin
                        air_state_o <= platformer_pkg::AIR_GROUNDED;
                    end else if (px_due) begin
                        air_cnt  <= '0;
                        pos_y_o  <= pos_y_o + 1'b1;
                        step_pix <= step_due ? '0 : step_pix + 1'b1;
                        // speeds up down to the terminal period
                        if (step_due && period > platformer_pkg::FALL_MIN_PERIOD) begin
                            period <= period - platformer_pkg::PERIOD_STEP;
                        end
                    end else begin
                        air_cnt <= air_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // a respawn is the only jump larger than one pixel
    assert property (@(posedge clk) disable iff (rst_i)
        !respawn_done_o |=>
            (pos_x_o == $past(pos_x_o) || pos_x_o == $past(pos_x_o) + 1'b1 ||
             pos_x_o == $past(pos_x_o) - 1'b1) &&
            (pos_y_o == $past(pos_y_o) || pos_y_o == $past(pos_y_o) + 1'b1 ||
             pos_y_o == $past(pos_y_o) - 1'b1));

endmodule

// File: hw/snowflake_tracker.sv
`timescale 1ns/1ps

module snowflake_tracker (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic [platformer_pkg::X_W-1:0]     pos_x_i,
    input  logic [platformer_pkg::Y_W-1:0]     pos_y_i,
    output logic [platformer_pkg::SCORE_W-1:0] score_o,
    output logic                               won_o
);

    localparam int FN = platformer_pkg::FLAKE_NUM;
    localparam int PW = platformer_pkg::PLAYER_W;
    localparam int PH = platformer_pkg::PLAYER_H;
    localparam int FW = platformer_pkg::FLAKE_W;
    localparam int FH = platformer_pkg::FLAKE_H;

    logic [FN-1:0] collected;
    logic [FN-1:0] overlap;
    logic [FN-1:0] pending;
    logic [FN-1:0] pick;

    always_comb begin
        int px;
        int py;
        int fx;
        int fy;
        px = int'(pos_x_i);
        py = int'(pos_y_i);
        for (int i = 0; i < FN; i++) begin
            fx         = int'(platformer_pkg::FLAKE_X[i]);
            fy         = int'(platformer_pkg::FLAKE_Y[i]);
            overlap[i] = (px < fx + FW) && (fx < px + PW) && (py < fy + FH) && (fy < py + PH);
        end
    end

    assign pending = overlap & ~collected;
    // lowest index first, the rest are taken on later cycles
    assign pick    = pending & (~pending + 1'b1);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            collected <= '0;
            score_o   <= '0;
        end else if (|pending) begin
            collected <= collected | pick;
            score_o   <= score_o + 1'b1;
        end
    end

    assign won_o = &collected;

    assert property (@(posedge clk) disable iff (rst_i)
        score_o <= FN);

endmodule

// File: hw/terrain_collision.sv
`timescale 1ns/1ps

module terrain_collision (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic [platformer_pkg::X_W-1:0] pos_x_i,
    input  logic [platformer_pkg::Y_W-1:0] pos_y_i,
    output logic                           hit_down_o,
    output logic                           hit_up_o,
    output logic                           hit_right_o,
    output logic                           hit_left_o
);

    localparam int PW = platformer_pkg::PLAYER_W;
    localparam int PH = platformer_pkg::PLAYER_H;
    localparam int BW = platformer_pkg::BLOCK_W;
    localparam int BH = platformer_pkg::BLOCK_H;

    logic down_any;
    logic up_any;
    logic right_any;
    logic left_any;

    always_comb begin
        int   px;
        int   py;
        int   bx;
        int   by;
        logic h_ovl;
        logic v_ovl;
        px        = int'(pos_x_i);
        py        = int'(pos_y_i);
        down_any  = 1'b0;
        up_any    = 1'b0;
        right_any = 1'b0;
        left_any  = 1'b0;
        for (int i = 0; i < platformer_pkg::BLOCK_NUM; i++) begin
            bx    = int'(platformer_pkg::BLOCK_X[i]);
            by    = int'(platformer_pkg::BLOCK_Y[i]);
            h_ovl = (px < bx + BW) && (bx < px + PW);
            v_ovl = (py < by + BH) && (by < py + PH);
            // edges touching, boxes never overlap
            if (h_ovl && (py + PH == by)) begin
                down_any = 1'b1;
            end
            if (h_ovl && (py == by + BH)) begin
                up_any = 1'b1;
            end
            if (v_ovl && (px + PW == bx)) begin
                right_any = 1'b1;
            end
            if (v_ovl && (bx + BW == px)) begin
                left_any = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hit_down_o  <= 1'b0;
            hit_up_o    <= 1'b0;
            hit_right_o <= 1'b0;
            hit_left_o  <= 1'b0;
        end else begin
            hit_down_o  <= down_any;
            hit_up_o    <= up_any;
            hit_right_o <= right_any;
            hit_left_o  <= left_any;
        end
    end

endmodule

// File: sim/platformer_tb.sv
`timescale 1ns/1ps

module platformer_tb;

    localparam int TICK_DIV     = 4;
    localparam int WALK_PERIOD  = 3;
    localparam int CLK_PERIOD   = 40;
    localparam int WALK_TARGET  = 90;
    localparam int SCORE_TARGET = 300;
    localparam int SPAWN_Y      = int'(platformer_pkg::SPAWN_Y);
    localparam int JUMP_LIMIT   = int'(platformer_pkg::JUMP_START_PERIOD) * TICK_DIV + 4;
    localparam int RESP_LIMIT   = TICK_DIV + 2;
    // head room below the left platform at x 90
    localparam int RISE_PIX     = SPAWN_Y - int'(platformer_pkg::BLOCK_Y[22]) -
                                  platformer_pkg::BLOCK_H;
    localparam int TEST_CYCLES  = 100 + (WALK_TARGET + SCORE_TARGET) * WALK_PERIOD * TICK_DIV +
        RISE_PIX * int'(platformer_pkg::JUMP_START_PERIOD + platformer_pkg::FALL_START_PERIOD) *
        TICK_DIV;
    localparam int TIMEOUT_NS   = TEST_CYCLES * CLK_PERIOD * 12 / 10;

    typedef enum int {
        PH_NONE, PH_RESET, PH_WALK, PH_IDLE, PH_JUMP, PH_RESPAWN, PH_SCORE, PH_SCORE_END
    } phase_e;

    logic                                   clk;
    logic                                   rst;
    logic                                   scan_valid;
    logic [7:0]                             scan_code;
    logic                                   scan_break;
    logic                                   scan_ready;
    logic [platformer_pkg::X_W-1:0]         pos_x;
    logic [platformer_pkg::Y_W-1:0]         pos_y;
    logic                                   facing_right;
    platformer_pkg::air_e                   air_state;
    logic [platformer_pkg::SCORE_W-1:0]     score;
    logic                                   won;
    logic                                   grounded;
    logic [platformer_pkg::FLAKE_NUM-1:0]   seen = '0;
    phase_e                                 phase = PH_NONE;
    logic                                   step_on = 1'b0;
    logic                                   walking_right = 1'b0;
    logic                                   jump_armed = 1'b0;
    logic                                   resp_armed = 1'b0;
    logic                                   saw_rising = 1'b0;
    logic                                   saw_falling = 1'b0;
    int                                     jump_cnt = 0;
    int                                     resp_cnt = 0;
    int                                     errors = 0;
    int                                     tests_run = 0;
    int                                     tests_failed = 0;
    logic [31:0]                            lcg_state = 32'h87f0_3fd7;

    tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) u_clock (.clk_o(clk), .rst_o(rst));

    platformer_core #(
        .TICK_DIV    (TICK_DIV),
        .WALK_PERIOD (WALK_PERIOD)
    ) UUT (
        .clk            (clk),
        .rst_i          (rst),
        .scan_valid_i   (scan_valid),
        .scan_code_i    (scan_code),
        .scan_break_i   (scan_break),
        .scan_ready_o   (scan_ready),
        .pos_x_o        (pos_x),
        .pos_y_o        (pos_y),
        .facing_right_o (facing_right),
        .air_state_o    (air_state),
        .score_o        (score),
        .won_o          (won)
    );

    assign grounded = (air_state == platformer_pkg::AIR_GROUNDED);

    function automatic logic [31:0] lcg_step();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // box overlap of the player at (px, py) with flake i
    function automatic bit overlaps_flake(input int i, input int px, input int py);
        int fx;
        int fy;
        fx = int'(platformer_pkg::FLAKE_X[i]);
        fy = int'(platformer_pkg::FLAKE_Y[i]);
        return (px < fx + platformer_pkg::FLAKE_W) && (fx < px + platformer_pkg::PLAYER_W) &&
               (py < fy + platformer_pkg::FLAKE_H) && (fy < py + platformer_pkg::PLAYER_H);
    endfunction

    function automatic bit moved_at_most_one(input int now_v, input int was_v);
        return (now_v - was_v <= 1) && (was_v - now_v <= 1);
    endfunction

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t ns: %s", $time, msg);
    endtask

    task automatic next_cycle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic idle_gap();
        next_cycle(int'(lcg_step() >> 30));
    endtask

    // present a code and hold it until the handshake completes
    task automatic send_key(input logic [7:0] code, input logic brk, input bit with_gap);
        logic taken;
        if (with_gap) begin
            idle_gap();
        end
        scan_valid = 1'b1;
        scan_code  = code;
        scan_break = brk;
        taken      = 1'b0;
        while (!taken) begin
            taken = scan_ready;
            next_cycle(1);
        end
        scan_valid = 1'b0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // counters and flags that the assertions look at
    always @(posedge clk) begin
        jump_cnt <= jump_armed ? jump_cnt + 1 : 0;
        resp_cnt <= resp_armed ? resp_cnt + 1 : 0;
        if (phase == PH_JUMP && air_state == platformer_pkg::AIR_RISING) begin
            saw_rising <= 1'b1;
        end
        if (phase == PH_JUMP && air_state == platformer_pkg::AIR_FALLING) begin
            saw_falling <= 1'b1;
        end
        for (int i = 0; i < platformer_pkg::FLAKE_NUM; i++) begin
            if (!rst && overlaps_flake(i, int'(pos_x), int'(pos_y))) begin
                seen[i] <= 1'b1;
            end
        end
    end

    reset_state: assert property (@(posedge clk) disable iff (rst)
        phase == PH_RESET |-> pos_x == platformer_pkg::SPAWN_X && int'(pos_y) == SPAWN_Y &&
            grounded && score == '0 && !won && scan_ready)
        else flag_mismatch("outputs differ from the reset state");

    walk_right: assert property (@(posedge clk) disable iff (rst)
        walking_right && $past(walking_right) |-> int'(pos_x) >= int'($past(pos_x)) &&
            int'(pos_x) <= int'($past(pos_x)) + 1 && facing_right)
        else flag_mismatch("x went back, skipped a pixel or faced left while walking right");

    single_step: assert property (@(posedge clk) disable iff (rst)
        step_on && $past(step_on) |-> moved_at_most_one(int'(pos_x), int'($past(pos_x))) &&
            moved_at_most_one(int'(pos_y), int'($past(pos_y))))
        else flag_mismatch("position moved by more than one pixel in a cycle");

    idle_still: assert property (@(posedge clk) disable iff (rst)
        phase == PH_IDLE && $past(phase) == PH_IDLE |-> $stable(pos_x) && $stable(pos_y) &&
            int'(pos_x) == WALK_TARGET && int'(pos_y) == SPAWN_Y && grounded)
        else flag_mismatch("player not resting at x 90 on the floor with no key held");

    jump_start: assert property (@(posedge clk) disable iff (rst)
        jump_armed && int'(pos_y) == SPAWN_Y |-> jump_cnt < JUMP_LIMIT)
        else flag_mismatch("jump did not lift the player in time");

    fall_after_rise: assert property (@(posedge clk) disable iff (rst)
        phase == PH_JUMP && air_state == platformer_pkg::AIR_FALLING |-> saw_rising)
        else flag_mismatch("falling without rising first");

    jump_landing: assert property (@(posedge clk) disable iff (rst)
        phase == PH_JUMP && $rose(grounded) |-> saw_rising && saw_falling &&
            int'(pos_y) == SPAWN_Y)
        else flag_mismatch("landing not at y 367 after rising and falling");

    ready_drop: assert property (@(posedge clk) disable iff (rst)
        $rose(resp_armed) |-> !scan_ready)
        else flag_mismatch("scan_ready still high after the respawn code was taken");

    ready_held_low: assert property (@(posedge clk) disable iff (rst)
        !scan_ready && !UUT.respawn_done |=> !scan_ready)
        else flag_mismatch("scan_ready rose before respawn_done");

    ready_release: assert property (@(posedge clk) disable iff (rst)
        $rose(scan_ready) |-> $past(UUT.respawn_done))
        else flag_mismatch("scan_ready rose without a respawn_done");

    no_accept: assert property (@(posedge clk) disable iff (rst)
        !scan_ready |=> $stable({UUT.hold_jump, UUT.hold_left, UUT.hold_right}))
        else flag_mismatch("a code was taken while scan_ready was low");

    respawn_time: assert property (@(posedge clk) disable iff (rst)
        resp_armed && !(pos_x == platformer_pkg::SPAWN_X && int'(pos_y) == SPAWN_Y) |->
            resp_cnt < RESP_LIMIT)
        else flag_mismatch("player not back at the spawn point in time");

    score_step: assert property (@(posedge clk) disable iff (rst)
        score == $past(score) || int'(score) == int'($past(score)) + 1)
        else flag_mismatch("score fell or rose by more than one");

    won_early: assert property (@(posedge clk) disable iff (rst)
        int'(score) < platformer_pkg::FLAKE_NUM |-> !won)
        else flag_mismatch("won_o high before every flake was taken");

    score_final: assert property (@(posedge clk) disable iff (rst)
        phase == PH_SCORE_END |-> int'(score) == $countones(seen))
        else flag_mismatch("score differs from the flakes the player touched");

    initial begin
        int mark;
        scan_valid = 1'b0;
        scan_code  = 8'h00;
        scan_break = 1'b0;
        wait (rst === 1'b0);

        mark  = errors;
        phase = PH_RESET;
        next_cycle(3);
        report_test("reset", mark);

        mark    = errors;
        phase   = PH_WALK;
        step_on = 1'b1;
        send_key(platformer_pkg::KEY_D, 1'b0, 1'b1);
        walking_right = 1'b1;
        while (int'(pos_x) != WALK_TARGET) begin
            next_cycle(1);
        end
        send_key(platformer_pkg::KEY_D, 1'b1, 1'b0);
        walking_right = 1'b0;
        next_cycle(2);
        phase = PH_IDLE;
        next_cycle(40);
        report_test("walking", mark);

        // W decodes to CMD_JUMP, released once the player is airborne
        mark  = errors;
        phase = PH_JUMP;
        send_key(platformer_pkg::KEY_W, 1'b0, 1'b1);
        jump_armed = 1'b1;
        while (int'(pos_y) == SPAWN_Y) begin
            next_cycle(1);
        end
        jump_armed = 1'b0;
        send_key(platformer_pkg::KEY_W, 1'b1, 1'b1);
        while (!(grounded && int'(pos_y) == SPAWN_Y)) begin
            next_cycle(1);
        end
        next_cycle(2);
        report_test("jump", mark);

        // the right key is offered while the respawn is still pending
        mark    = errors;
        phase   = PH_RESPAWN;
        step_on = 1'b0;
        send_key(platformer_pkg::KEY_R, 1'b0, 1'b1);
        resp_armed = 1'b1;
        send_key(platformer_pkg::KEY_D, 1'b0, 1'b0);
        // keep watching until the respawn deadline has passed
        while (resp_cnt <= RESP_LIMIT) begin
            next_cycle(1);
        end
        resp_armed = 1'b0;
        report_test("respawn", mark);

        mark          = errors;
        phase         = PH_SCORE;
        step_on       = 1'b1;
        walking_right = 1'b1;
        while (int'(pos_x) != SCORE_TARGET) begin
            next_cycle(1);
        end
        send_key(platformer_pkg::KEY_D, 1'b1, 1'b0);
        walking_right = 1'b0;
        next_cycle(platformer_pkg::FLAKE_NUM + 2);
        phase = PH_SCORE_END;
        next_cycle(2);
        phase = PH_NONE;
        report_test("score", mark);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // released just after an edge, like every other input
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rst_o = 1'b0;
    end

endmodule
